/* bg_pkg.sv */
`default_nettype none

package bg_pkg;

    //////////////////////////////////////////////////
    // Vector types
    //////////////////////////////////////////////////

    // Raw horizontal or vertical counter value
    typedef logic [9:0] count_t;
    // Tile row or column on the 20 x 15 grid
    typedef logic [4:0] tile_idx_t;
    // Coordinate inside one 32 x 32 tile
    typedef logic [4:0] texel_t;
    // Index into the 16 entry palette
    typedef logic [3:0] pal_idx_t;
    // Colour as {red[2:0], green[2:0], blue[2:0]}
    typedef logic [8:0] rgb333_t;

    //////////////////////////////////////////////////
    // Screen geometry
    //////////////////////////////////////////////////

    localparam count_t    H_VISIBLE       = 10'd640;
    localparam count_t    V_VISIBLE       = 10'd480;
    // Tiles are 32 pixels square
    localparam int        TILE_SHIFT      = 5;
    localparam tile_idx_t ROWS_PER_SCREEN = 5'd15;
    // Decode, shade and output registers
    localparam int        PIPE_LATENCY    = 3;

    // Terrain kind of one tile
    typedef enum logic [2:0] {
        T_NONE,
        T_GRASS,
        T_SIDEWALK,
        T_ROAD,
        T_WATER_LINE,
        T_FINISH
    } terrain_e;

    //////////////////////////////////////////////////
    // Palette
    //////////////////////////////////////////////////

    localparam pal_idx_t PAL_BLACK   = 4'd0;
    localparam pal_idx_t PAL_GRASS_L = 4'd1;
    localparam pal_idx_t PAL_GRASS_D = 4'd2;
    localparam pal_idx_t PAL_KERB    = 4'd3;
    localparam pal_idx_t PAL_SLAB    = 4'd4;
    localparam pal_idx_t PAL_LANE    = 4'd5;
    localparam pal_idx_t PAL_ASPHALT = 4'd6;
    localparam pal_idx_t PAL_WATER_L = 4'd7;
    localparam pal_idx_t PAL_WATER_D = 4'd8;
    localparam pal_idx_t PAL_FLAG_W  = 4'd9;
    localparam pal_idx_t PAL_FLAG_G  = 4'd10;

    // Entry order follows the index names above
    localparam rgb333_t PALETTE [16] = '{
        9'b000_000_000,  // black
        9'b010_110_001,  // light grass
        9'b001_100_000,  // dark grass
        9'b101_101_101,  // kerb grey
        9'b100_100_100,  // slab grey
        9'b111_111_111,  // lane white
        9'b010_010_010,  // asphalt
        9'b010_100_111,  // light water
        9'b000_010_110,  // dark water
        9'b111_111_111,  // flag white
        9'b000_111_000,  // flag green
        9'b000_000_000,
        9'b000_000_000,
        9'b000_000_000,
        9'b000_000_000,
        9'b000_000_000
    };

endpackage

`default_nettype wire

/* tile_if.sv */
`default_nettype none
`timescale 1ns/1ns

interface tile_if
    import bg_pkg::*;
();

    // Beat strobe, no back-pressure
    logic     valid;
    // Pixel lies inside the 640 x 480 area
    logic     visible;
    // Terrain of the tile under the pixel
    terrain_e kind;
    // Position inside the tile
    texel_t   tex_x;
    texel_t   tex_y;

    // Decode side
    modport src (output valid, output visible, output kind, output tex_x, output tex_y);

    // Shading side
    modport snk (input valid, input visible, input kind, input tex_x, input tex_y);

endinterface

`default_nettype wire

/* bg_tile_decode.sv */
`default_nettype none
`timescale 1ns/1ns

module bg_tile_decode
    import bg_pkg::*;
(
    input  wire     i_Clk,
    input  wire     i_rst_n,

    // Counters from the timing generator
    input  count_t  i_h_count,
    input  count_t  i_v_count,
    input  wire     i_pix_valid,

    // Decoded tile towards shading
    tile_if.src     o_tile
);

    //////////////////////////////////////////////////
    // Tile position
    //////////////////////////////////////////////////

    logic      pix_visible;
    tile_idx_t tile_row;
    tile_idx_t tile_col;
    terrain_e  tile_kind;

    // Upper counter bits select the tile
    assign tile_row = i_v_count[9:TILE_SHIFT];
    assign tile_col = i_h_count[9:TILE_SHIFT];

    assign pix_visible = (i_h_count < H_VISIBLE) && (i_v_count < V_VISIBLE);

    //////////////////////////////////////////////////
    // Row map
    //////////////////////////////////////////////////

    always_comb
    begin
        tile_kind = T_NONE;
        if (pix_visible)
        begin
            case (tile_row)
                // Goal row has the flag only in the left corner
                5'd0:
                begin
                    if (tile_col == 5'd0)
                        tile_kind = T_FINISH;
                    else
                        tile_kind = T_WATER_LINE;
                end
                5'd1, 5'd2, 5'd12, 5'd13, 5'd14:
                    tile_kind = T_GRASS;
                5'd3, 5'd5, 5'd7, 5'd9, 5'd11:
                    tile_kind = T_SIDEWALK;
                5'd4, 5'd6, 5'd8, 5'd10:
                    tile_kind = T_ROAD;
                default:
                    tile_kind = T_NONE;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Stage register
    //////////////////////////////////////////////////

    always_ff @(posedge i_Clk)
    begin
        if (!i_rst_n)
            o_tile.valid <= 1'b0;
        else
            o_tile.valid <= i_pix_valid;

        // Payload follows every cycle
        o_tile.visible <= pix_visible;
        o_tile.kind    <= tile_kind;
        // Low counter bits are the texel coordinates
        o_tile.tex_x   <= i_h_count[TILE_SHIFT-1:0];
        o_tile.tex_y   <= i_v_count[TILE_SHIFT-1:0];
    end

endmodule

`default_nettype wire

/* bg_texel_shade.sv */
`default_nettype none
`timescale 1ns/1ns

module bg_texel_shade
    import bg_pkg::*;
(
    input  wire      i_Clk,
    input  wire      i_rst_n,

    // Decoded tile from decode
    tile_if.snk      i_tile,

    // Shaded pixel towards output
    output logic     o_valid,
    output logic     o_visible,
    output pal_idx_t o_pal_idx
);

    //////////////////////////////////////////////////
    // Texture helpers
    //////////////////////////////////////////////////

    pal_idx_t next_idx;
    texel_t   tex_sum;
    logic     grass_odd;
    logic     kerb_edge;
    logic     lane_mark;

    // Diagonal bands on the water line, wraps at 32
    assign tex_sum   = i_tile.tex_x + i_tile.tex_y;

    // 4 x 4 checker on grass
    assign grass_odd = i_tile.tex_x[2] ^ i_tile.tex_y[2];

    // One texel border on top and left of each slab
    assign kerb_edge = (i_tile.tex_x == 5'd0) || (i_tile.tex_y == 5'd0);

    // Dashed centre stripe, 4 lines tall
    assign lane_mark = (i_tile.tex_y >= 5'd14) && (i_tile.tex_y <= 5'd17) &&
                       !i_tile.tex_x[3];

    //////////////////////////////////////////////////
    // Texture rules
    //////////////////////////////////////////////////

    always_comb
    begin
        case (i_tile.kind)
            T_GRASS:
                next_idx = grass_odd ? PAL_GRASS_D : PAL_GRASS_L;
            T_SIDEWALK:
                next_idx = kerb_edge ? PAL_KERB : PAL_SLAB;
            T_ROAD:
                next_idx = lane_mark ? PAL_LANE : PAL_ASPHALT;
            T_WATER_LINE:
                next_idx = tex_sum[2] ? PAL_WATER_D : PAL_WATER_L;
            // Lower left triangle white, upper right green
            T_FINISH:
                next_idx = (i_tile.tex_x < i_tile.tex_y) ? PAL_FLAG_W : PAL_FLAG_G;
            default:
                next_idx = PAL_BLACK;
        endcase
    end

    //////////////////////////////////////////////////
    // Stage register
    //////////////////////////////////////////////////

    always_ff @(posedge i_Clk)
    begin
        if (!i_rst_n)
            o_valid <= 1'b0;
        else
            o_valid <= i_tile.valid;

        // Visible flag rides along with the index
        o_visible <= i_tile.visible;
        o_pal_idx <= next_idx;
    end

endmodule

`default_nettype wire

/* bg_pixel_out.sv */
`default_nettype none
`timescale 1ns/1ns

module bg_pixel_out
    import bg_pkg::*;
(
    input  wire      i_Clk,
    input  wire      i_rst_n,

    // Shaded pixel from shading
    input  wire      i_valid,
    input  wire      i_visible,
    input  pal_idx_t i_pal_idx,

    // Pixel to the VGA DAC
    output rgb333_t  o_vga_pixel,
    output logic     o_pixel_valid
);

    //////////////////////////////////////////////////
    // Palette lookup
    //////////////////////////////////////////////////

    rgb333_t pal_color;

    // Blanking area is always black
    assign pal_color = i_visible ? PALETTE[i_pal_idx] : PALETTE[PAL_BLACK];

    //////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////

    always_ff @(posedge i_Clk)
    begin
        if (!i_rst_n)
        begin
            o_vga_pixel   <= '0;
            o_pixel_valid <= 1'b0;
        end
        else
        begin
            o_pixel_valid <= i_valid;
            // Colour held between beats
            if (i_valid)
                o_vga_pixel <= pal_color;
        end
    end

endmodule

`default_nettype wire

/* bg_display.sv */
`default_nettype none
`timescale 1ns/1ns

module bg_display
    import bg_pkg::*;
(
    input  wire      i_Clk,
    input  wire      i_rst_n,

    // Counters and strobe from the timing generator
    input  count_t   i_h_count,
    input  count_t   i_v_count,
    input  wire      i_pix_valid,

    // Background pixel, 3 cycles after the counters
    output rgb333_t  o_vga_pixel,
    output logic     o_pixel_valid
);

    //////////////////////////////////////////////////
    // Stage links
    //////////////////////////////////////////////////

    // Decode to shading
    tile_if u_tile_if ();

    // Shading to output
    logic     shade_valid;
    logic     shade_visible;
    pal_idx_t shade_pal_idx;

    //////////////////////////////////////////////////
    // Pipeline
    //////////////////////////////////////////////////

    bg_tile_decode u_decode (
        .i_Clk       (i_Clk),
        .i_rst_n     (i_rst_n),
        .i_h_count   (i_h_count),
        .i_v_count   (i_v_count),
        .i_pix_valid (i_pix_valid),
        .o_tile      (u_tile_if.src)
    );

    bg_texel_shade u_shade (
        .i_Clk       (i_Clk),
        .i_rst_n     (i_rst_n),
        .i_tile      (u_tile_if.snk),
        .o_valid     (shade_valid),
        .o_visible   (shade_visible),
        .o_pal_idx   (shade_pal_idx)
    );

    bg_pixel_out u_out (
        .i_Clk         (i_Clk),
        .i_rst_n       (i_rst_n),
        .i_valid       (shade_valid),
        .i_visible     (shade_visible),
        .i_pal_idx     (shade_pal_idx),
        .o_vga_pixel   (o_vga_pixel),
        .o_pixel_valid (o_pixel_valid)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none
`timescale 1ns/1ns

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst_n
);

    // 100 ns period
    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 10;

    initial
    begin
        o_clk = 1'b0;
        forever
            #HALF_PERIOD o_clk = ~o_clk;
    end

    // Reset held for 10 rising edges, released on a falling edge
    initial
    begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES)
            @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* tb_bg_display.sv */
`default_nettype none
`timescale 1ns/1ns

module tb_bg_display
    import bg_pkg::*;
();

    //////////////////////////////////////////////////
    // Run length and watchdog
    //////////////////////////////////////////////////

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int N_RANDOM     = 200;
    // Row map 16, texture 24, blanking 8, bubbles 20
    localparam int TABLE_LEN    = 68;
    localparam int WATCHDOG_NS  =
        2 * (TABLE_LEN + N_RANDOM + PIPE_LATENCY + RESET_CYCLES) * CLK_PERIOD;
    // Valid pattern of the bubble test with the LSB first
    localparam logic [19:0] BUBBLE_MASK = 20'b1101_1000_1110_0110_1011;

    // Reference colours in RGB333
    localparam rgb333_t C_BLACK   = 9'b000_000_000;
    localparam rgb333_t C_GRASS_L = 9'b010_110_001;
    localparam rgb333_t C_GRASS_D = 9'b001_100_000;
    localparam rgb333_t C_KERB    = 9'b101_101_101;
    localparam rgb333_t C_SLAB    = 9'b100_100_100;
    localparam rgb333_t C_LANE    = 9'b111_111_111;
    localparam rgb333_t C_ASPHALT = 9'b010_010_010;
    localparam rgb333_t C_WATER_L = 9'b010_100_111;
    localparam rgb333_t C_WATER_D = 9'b000_010_110;
    localparam rgb333_t C_FLAG_W  = 9'b111_111_111;
    localparam rgb333_t C_FLAG_G  = 9'b000_111_000;

    logic    clk;
    logic    rst_n;
    count_t  h_count;
    count_t  v_count;
    logic    pix_valid;
    rgb333_t vga_pixel;
    logic    pixel_valid;

    integer  seed = 32'h217f4047;
    int      cycle_count = 0;
    int      error_count = 0;
    int      beat_count = 0;
    int      pass_tests = 0;
    int      fail_tests = 0;
    int      errors_before;
    int      i;

    // Stimulus table
    int      tab_h[$];
    int      tab_v[$];
    bit      tab_valid[$];
    rgb333_t tab_exp[$];

    // Pixels in flight and the cycle their output is due
    rgb333_t fly_exp[$];
    int      fly_due[$];
    int      fly_h[$];
    int      fly_v[$];
    rgb333_t m_exp;
    int      m_due;
    int      m_h;
    int      m_v;

    tb_clock_gen u_clock_gen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    bg_display uut (
        .i_Clk         (clk),
        .i_rst_n       (rst_n),
        .i_h_count     (h_count),
        .i_v_count     (v_count),
        .i_pix_valid   (pix_valid),
        .o_vga_pixel   (vga_pixel),
        .o_pixel_valid (pixel_valid)
    );

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic rgb333_t ref_color(input int h, input int v);
        int tx;
        int ty;
        int row;
        tx  = h % 32;
        ty  = v % 32;
        row = v / 32;
        if (h >= 640 || v >= 480)
            return C_BLACK;
        // Goal row with the flag tile at column 0
        if (row == 0 && h < 32)
            return (tx < ty) ? C_FLAG_W : C_FLAG_G;
        if (row == 0)
            return ((((tx + ty) % 32) / 4) % 2 == 1) ? C_WATER_D : C_WATER_L;
        // Grass at rows 1, 2 and 12 to 14
        if (row <= 2 || row >= 12)
            return (((tx / 4) % 2) != ((ty / 4) % 2)) ? C_GRASS_D : C_GRASS_L;
        // Odd rows in between are sidewalk, even rows road
        if (row % 2 == 1)
            return (tx == 0 || ty == 0) ? C_KERB : C_SLAB;
        return (ty >= 14 && ty <= 17 && ((tx / 8) % 2 == 0)) ? C_LANE : C_ASPHALT;
    endfunction

    //////////////////////////////////////////////////
    // Table handling
    //////////////////////////////////////////////////

    task automatic add_entry(input int h, input int v, input bit valid);
        tab_h.push_back(h);
        tab_v.push_back(v);
        tab_valid.push_back(valid);
        tab_exp.push_back(ref_color(h, v));
    endtask

    // Random visible coordinate
    task automatic add_random(input bit valid);
        int h;
        int v;
        h = {$random(seed)} % 640;
        v = {$random(seed)} % 480;
        add_entry(h, v, valid);
    endtask

    task automatic report_test(input string name, input int errs_at_start);
        if (error_count == errs_at_start)
        begin
            pass_tests++;
            $display("Test %s passed", name);
        end
        else
        begin
            fail_tests++;
            $display("Test %s had %0d errors", name, error_count - errs_at_start);
        end
    endtask

    // Drive the table one entry per cycle, then wait for the pipeline to drain
    task automatic run_table(input string name);
        int errs_at_start;
        int k;
        errs_at_start = error_count;
        for (k = 0; k < tab_h.size(); k++)
        begin
            @(negedge clk);
            h_count   = tab_h[k];
            v_count   = tab_v[k];
            pix_valid = tab_valid[k];
            if (tab_valid[k])
            begin
                fly_exp.push_back(tab_exp[k]);
                fly_due.push_back(cycle_count + PIPE_LATENCY);
                fly_h.push_back(tab_h[k]);
                fly_v.push_back(tab_v[k]);
            end
        end
        @(negedge clk);
        pix_valid = 1'b0;
        while (fly_exp.size() != 0)
            @(negedge clk);
        tab_h.delete();
        tab_v.delete();
        tab_valid.delete();
        tab_exp.delete();
        report_test(name, errs_at_start);
    endtask

    //////////////////////////////////////////////////
    // Output monitor
    //////////////////////////////////////////////////

    always @(posedge clk)
        cycle_count <= cycle_count + 1;

    // Compare each output beat on the falling edge
    always @(negedge clk)
    begin
        if (rst_n && pixel_valid)
        begin
            if (fly_exp.size() == 0)
            begin
                $display("Output beat at cycle %0d with no pixel in flight", cycle_count);
                error_count++;
            end
            else
            begin
                m_exp = fly_exp.pop_front();
                m_due = fly_due.pop_front();
                m_h   = fly_h.pop_front();
                m_v   = fly_v.pop_front();
                beat_count++;
                if (m_due != cycle_count)
                begin
                    $display("Output beat at cycle %0d, expected at cycle %0d",
                             cycle_count, m_due);
                    error_count++;
                end
                if (vga_pixel !== m_exp)
                begin
                    $display("Fail o_vga_pixel exp=%03h got=%03h (h=%0d v=%0d)",
                             m_exp, vga_pixel, m_h, m_v);
                    error_count++;
                end
            end
        end
        else if (rst_n && fly_due.size() != 0 && fly_due[0] <= cycle_count)
        begin
            m_exp = fly_exp.pop_front();
            m_due = fly_due.pop_front();
            m_h   = fly_h.pop_front();
            m_v   = fly_v.pop_front();
            $display("Output beat missing at cycle %0d for h=%0d v=%0d", m_due, m_h, m_v);
            error_count++;
        end
    end

    // Watchdog
    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all tests finished");
        $display("Simulation failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial
    begin
        h_count   = '0;
        v_count   = '0;
        pix_valid = 1'b0;
        @(posedge rst_n);

        // Idle outputs after reset
        errors_before = error_count;
        repeat (3)
        begin
            @(negedge clk);
            if (pixel_valid !== 1'b0)
            begin
                $display("Fail o_pixel_valid exp=0 got=%h", pixel_valid);
                error_count++;
            end
            if (vga_pixel !== 9'h000)
            begin
                $display("Fail o_vga_pixel exp=000 got=%03h", vga_pixel);
                error_count++;
            end
        end
        report_test("reset", errors_before);

        // Texel (1,1) of every row plus the water line in row 0
        for (i = 0; i < 15; i++)
            add_entry(32 * i + 1, 32 * i + 1, 1'b1);
        add_entry(33, 1, 1'b1);
        run_table("row_map");

        // Grass checker in row 1
        add_entry(4, 32, 1'b1);
        add_entry(4, 36, 1'b1);
        add_entry(0, 36, 1'b1);
        add_entry(0, 32, 1'b1);
        // Kerb edges and slab in row 3 column 2
        add_entry(64, 101, 1'b1);
        add_entry(69, 96, 1'b1);
        add_entry(69, 101, 1'b1);
        add_entry(95, 127, 1'b1);
        // Lane stripe limits in row 4
        add_entry(0, 142, 1'b1);
        add_entry(7, 145, 1'b1);
        add_entry(8, 143, 1'b1);
        add_entry(0, 141, 1'b1);
        add_entry(0, 146, 1'b1);
        add_entry(16, 144, 1'b1);
        // Water bands where the sum wraps at 32
        add_entry(32, 0, 1'b1);
        add_entry(36, 0, 1'b1);
        add_entry(34, 2, 1'b1);
        add_entry(63, 1, 1'b1);
        add_entry(62, 7, 1'b1);
        // Flag diagonal
        add_entry(0, 1, 1'b1);
        add_entry(1, 0, 1'b1);
        add_entry(5, 5, 1'b1);
        add_entry(3, 20, 1'b1);
        add_entry(31, 31, 1'b1);
        run_table("texture");

        // Just outside and just inside the visible area
        add_entry(640, 0, 1'b1);
        add_entry(700, 100, 1'b1);
        add_entry(1023, 1023, 1'b1);
        add_entry(0, 480, 1'b1);
        add_entry(639, 480, 1'b1);
        add_entry(640, 479, 1'b1);
        add_entry(100, 600, 1'b1);
        add_entry(639, 479, 1'b1);
        run_table("blanking");

        for (i = 0; i < N_RANDOM; i++)
            add_random(1'b1);
        run_table("burst");

        for (i = 0; i < 20; i++)
            add_random(BUBBLE_MASK[i]);
        run_table("bubbles");

        $display("Tests passed %0d, tests failed %0d, beats checked %0d, errors %0d",
                 pass_tests, fail_tests, beat_count, error_count);
        if (fail_tests == 0 && error_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
bg_pkg.sv
tile_if.sv
bg_tile_decode.sv
bg_texel_shade.sv
bg_pixel_out.sv
bg_display.sv
tb_clock_gen.sv
tb_bg_display.sv
